//--- dv/fetch_tb.sv
////////////////////
// testbench for the two-wide fetch front end
// memory model answers imem_addr in the same cycle
// reference model tracks pc, counters and target buffer
// stimulus from a galois lfsr, dispatch clamped to the expected valid slots
////////////////////
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*;
();

	localparam logic [31:0] MEM_KEY      = 32'h5a3c_96e1;  // memory fill pattern
	localparam logic [31:0] LFSR_SEED    = 32'hf6e72897;
	localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
	localparam int          TIMEOUT_CYC  = 50;
	localparam int          RANDOM_CYC   = 4000;

	logic clock;
	logic reset;

	addr_t         imem_addr;
	mem_word_t     imem_data;
	logic          imem_valid;
	dispatch_cnt_t dispatch_num;
	logic          slot0_valid, slot1_valid;
	instr_t        slot0_instr, slot1_instr;
	addr_t         slot0_npc, slot1_npc;
	logic          slot0_pred_taken, slot1_pred_taken;
	addr_t         slot0_pred_target, slot1_pred_target;
	logic          resolve_valid;
	addr_t         resolve_pc;
	logic          resolve_taken;
	addr_t         resolve_target;

	// reference model state
	addr_t      m_pc;
	logic [1:0] m_ctr [BHT_ENTRIES];    // 0 strong not taken .. 3 strong taken
	logic       m_btb_v [BTB_ENTRIES];
	addr_t      m_btb_pc [BTB_ENTRIES]; // whole resolve pc, tag is bits 63:7
	addr_t      m_btb_tgt [BTB_ENTRIES];

	// inputs applied in the current cycle
	logic          cur_valid;
	dispatch_cnt_t cur_disp;
	logic          cur_rv, cur_rt;
	addr_t         cur_rpc, cur_rtgt;

	// expected outputs
	addr_t  exp_addr;
	logic   exp_v0, exp_v1, exp_t0, exp_t1;
	instr_t exp_i0, exp_i1;
	addr_t  exp_n0, exp_n1, exp_g0, exp_g1;

	logic [31:0] lfsr_state = LFSR_SEED;
	int          errors     = 0;
	int          timeouts   = 0;
	logic        checks_on  = 1'b0;

	fetch_top uut
	(
		.clock (clock), .reset (reset),
		.imem_addr (imem_addr), .imem_data (imem_data), .imem_valid (imem_valid),
		.slot0_valid (slot0_valid), .slot0_instr (slot0_instr), .slot0_npc (slot0_npc),
		.slot0_pred_taken (slot0_pred_taken), .slot0_pred_target (slot0_pred_target),
		.slot1_valid (slot1_valid), .slot1_instr (slot1_instr), .slot1_npc (slot1_npc),
		.slot1_pred_taken (slot1_pred_taken), .slot1_pred_target (slot1_pred_target),
		.dispatch_num (dispatch_num),
		.resolve_valid (resolve_valid), .resolve_pc (resolve_pc),
		.resolve_taken (resolve_taken), .resolve_target (resolve_target)
	);

	////////////////////
	// memory model and random source
	////////////////////
	// both address halves folded in
	function automatic mem_word_t mem_word(input addr_t a);
		addr_t  a4;
		instr_t lo;
		instr_t hi;
		a4 = a + 64'd4;
		lo = a[31:0] ^ a[63:32] ^ MEM_KEY;
		hi = a4[31:0] ^ a4[63:32] ^ MEM_KEY;  // upper half is the next instruction address
		return {hi, lo};
	endfunction

	assign imem_data = mem_word(imem_addr);

	// galois lfsr, one step per bit taken
	function logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	////////////////////
	// reference model
	////////////////////
	// hit on full tag and counter in the upper half
	function logic ref_hit(input addr_t pc);
		return m_btb_v[pc[6:2]] && (m_btb_pc[pc[6:2]][63:7] == pc[63:7]) && m_ctr[pc[7:2]][1];
	endfunction

	function void ref_expect(input addr_t pc, input logic valid);
		addr_t     pc4;
		mem_word_t word;
		pc4 = pc + 64'd4;
		word = mem_word({pc[63:3], 3'b000});
		exp_addr = {pc[63:3], 3'b000};
		exp_v0 = valid;
		exp_i0 = pc[2] ? word[63:32] : word[31:0];
		exp_n0 = pc4;
		exp_t0 = valid && ref_hit(pc);
		exp_g0 = exp_t0 ? m_btb_tgt[pc[6:2]] : '0;
		exp_v1 = valid && !pc[2] && !exp_t0;   // taken slot 0 kills slot 1
		exp_i1 = word[63:32];
		exp_n1 = pc + 64'd8;
		exp_t1 = exp_v1 && ref_hit(pc4);
		exp_g1 = exp_t1 ? m_btb_tgt[pc4[6:2]] : '0;
	endfunction

	// advance model by one edge with the current inputs
	task step_model();
		ref_expect(m_pc, cur_valid);
		if (cur_disp == 2'd1)
			m_pc = exp_t0 ? exp_g0 : exp_n0;
		else if (cur_disp == 2'd2)
			m_pc = exp_t1 ? exp_g1 : exp_n1;
		if (cur_rv)
		begin
			if (cur_rt && m_ctr[cur_rpc[7:2]] != 2'd3)
				m_ctr[cur_rpc[7:2]] = m_ctr[cur_rpc[7:2]] + 2'd1;
			else if (!cur_rt && m_ctr[cur_rpc[7:2]] != 2'd0)
				m_ctr[cur_rpc[7:2]] = m_ctr[cur_rpc[7:2]] - 2'd1;
			if (cur_rt)
			begin
				m_btb_v[cur_rpc[6:2]]   = 1'b1;
				m_btb_pc[cur_rpc[6:2]]  = cur_rpc;
				m_btb_tgt[cur_rpc[6:2]] = cur_rtgt;
			end
		end
	endtask

	task check(input string name, input logic [63:0] actual, input logic [63:0] expected);
		if (actual !== expected)
		begin
			errors++;
			$display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	////////////////////
	// stimulus
	////////////////////
	task drive_cycle(input logic v, input dispatch_cnt_t d, input logic rv,
		input addr_t rpc, input logic rt, input addr_t rtgt);
		dispatch_cnt_t cnt;
		@(posedge clock);
		step_model();
		ref_expect(m_pc, v);
		cnt = dispatch_cnt_t'(exp_v0) + dispatch_cnt_t'(exp_v1);
		cur_valid = v;
		cur_disp = (d > cnt) ? cnt : d;     // decode never takes more than offered
		cur_rv = rv;
		cur_rpc = rpc;
		cur_rt = rt;
		cur_rtgt = rtgt;
		imem_valid <= cur_valid;
		dispatch_num <= cur_disp;
		resolve_valid <= rv;
		resolve_pc <= rpc;
		resolve_taken <= rt;
		resolve_target <= rtgt;
	endtask

	task hold_cycle();
		drive_cycle(1'b1, 2'd0, 1'b0, '0, 1'b0, '0);
	endtask

	// leave pc on an even word position, held
	task make_aligned();
		hold_cycle();
		if (m_pc[2])
		begin
			drive_cycle(1'b1, 2'd1, 1'b0, '0, 1'b0, '0);
			hold_cycle();
		end
	endtask

	task train_and_check(input addr_t pc, input logic taken, input addr_t tgt,
		input int times, input logic expect_taken);
		for (int i = 0; i < times; i++)
			drive_cycle(1'b1, 2'd0, 1'b1, pc, taken, tgt);
		hold_cycle();                       // last resolve lands at this edge
		@(negedge clock);
		check("slot0_pred_taken", 64'(slot0_pred_taken), 64'(expect_taken));
	endtask

	task wait_for_addr(input addr_t a);
		int n;
		n = 0;
		@(negedge clock);
		while (imem_addr !== a)
		begin
			if (n >= TIMEOUT_CYC)
			begin
				timeouts++;
				$display("timed out waiting for imem_addr to reach %h", a);
				return;
			end
			hold_cycle();
			@(negedge clock);
			n++;
		end
	endtask

	////////////////////
	// compare process
	////////////////////
	initial
	begin
		forever
		begin
			@(negedge clock);
			if (checks_on)
			begin
				ref_expect(m_pc, cur_valid);
				check("imem_addr", imem_addr, exp_addr);
				check("slot0_valid", 64'(slot0_valid), 64'(exp_v0));
				check("slot1_valid", 64'(slot1_valid), 64'(exp_v1));
				check("slot0_pred_taken", 64'(slot0_pred_taken), 64'(exp_t0));
				check("slot1_pred_taken", 64'(slot1_pred_taken), 64'(exp_t1));
				check("slot0_pred_target", slot0_pred_target, exp_g0);
				check("slot1_pred_target", slot1_pred_target, exp_g1);
				if (exp_v0)
				begin
					check("slot0_instr", 64'(slot0_instr), 64'(exp_i0));
					check("slot0_npc", slot0_npc, exp_n0);
				end
				if (exp_v1)
				begin
					check("slot1_instr", 64'(slot1_instr), 64'(exp_i1));
					check("slot1_npc", slot1_npc, exp_n1);
				end
			end
		end
	end

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task run_phases();
		logic [31:0] r1, r2, r3, r4, r5, r6;
		addr_t       a;
		addr_t       br;
		instr_t      saved;
		mem_word_t   word;
		// reset state, memory answering
		hold_cycle();
		@(negedge clock);
		check("imem_addr", imem_addr, '0);
		check("slot0_pred_taken", 64'(slot0_pred_taken), '0);
		check("slot1_pred_taken", 64'(slot1_pred_taken), '0);
		// sequential fetch, pc steps by 8
		for (int i = 0; i < 4; i++)
		begin
			drive_cycle(1'b1, 2'd2, 1'b0, '0, 1'b0, '0);
			@(negedge clock);
			check("imem_addr", imem_addr, 64'(8 * i));
		end
		drive_cycle(1'b1, 2'd1, 1'b0, '0, 1'b0, '0);
		hold_cycle();                       // pc now 36, odd position
		@(negedge clock);
		word = mem_word(64'd32);
		check("slot1_valid", 64'(slot1_valid), '0);
		check("slot0_instr", 64'(slot0_instr), 64'(word[63:32]));
		// stalls and back-pressure
		drive_cycle(1'b0, 2'd2, 1'b0, '0, 1'b0, '0);
		@(negedge clock);
		a = {m_pc[63:3], 3'b000};
		hold_cycle();
		@(negedge clock);
		check("imem_addr", imem_addr, a);
		make_aligned();
		@(negedge clock);
		word = mem_word({m_pc[63:3], 3'b000});
		saved = word[63:32];                // slot 1 of the current word
		drive_cycle(1'b1, 2'd1, 1'b0, '0, 1'b0, '0);
		hold_cycle();
		@(negedge clock);
		check("slot0_instr", 64'(slot0_instr), 64'(saved));
		// training and redirect
		make_aligned();
		br = m_pc;
		train_and_check(br, 1'b1, 64'h1000, 2, 1'b1);
		check("slot0_pred_target", slot0_pred_target, 64'h1000);
		check("slot1_valid", 64'(slot1_valid), '0);
		drive_cycle(1'b1, 2'd1, 1'b0, '0, 1'b0, '0);
		wait_for_addr(64'h1000);
		if (timeouts != 0)
			return;
		// saturation, untraining and replacement at 0x1000
		train_and_check(64'h1000, 1'b1, 64'h2000, 2, 1'b1);
		train_and_check(64'h1000, 1'b0, 64'h2000, 2, 1'b0);
		train_and_check(64'h1000, 1'b1, 64'h2000, 2, 1'b1);
		train_and_check(64'h1080, 1'b1, 64'h3000, 1, 1'b0);   // same btb index, new tag
		// random run
		for (int n = 0; n < RANDOM_CYC; n++)
		begin
			r1 = rand_bits(2);
			r2 = rand_bits(2);
			r3 = rand_bits(2);
			r4 = rand_bits(8);
			r5 = rand_bits(1);
			r6 = rand_bits(8);
			drive_cycle(r1[1:0] != 2'd0, r2[1:0], r3[1:0] == 2'd0,
				{54'd0, r4[7:0], 2'b00}, r5[0], {54'd0, r6[7:0], 2'b00});
		end
		hold_cycle();
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial
	begin
		reset = 1'b1;
		imem_valid = 1'b0;
		dispatch_num = 2'd0;
		resolve_valid = 1'b0;
		resolve_pc = '0;
		resolve_taken = 1'b0;
		resolve_target = '0;
		cur_valid = 1'b0;
		cur_disp = 2'd0;
		cur_rv = 1'b0;
		cur_rt = 1'b0;
		cur_rpc = '0;
		cur_rtgt = '0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		m_pc = RESET_PC;
		for (int i = 0; i < BHT_ENTRIES; i++)
			m_ctr[i] = 2'd1;                // weak not taken
		for (int j = 0; j < BTB_ENTRIES; j++)
			m_btb_v[j] = 1'b0;
		checks_on = 1'b1;
		run_phases();
		checks_on = 1'b0;
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- filelist.f
hw/fetch_pkg.sv
hw/pred_if.sv
hw/branch_predictor.sv
hw/fetch_stage.sv
hw/fetch_top.sv
dv/fetch_tb.sv

//--- hw/branch_predictor.sv
////////////////////
// two-bit counter table beside a direct-mapped target buffer
// both slots look up combinationally in the same cycle
// a resolve changes the tables at the edge, seen by lookups one cycle later
// resolve only trains, no misprediction recovery here
////////////////////
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*;
(
	input  logic      clock,
	input  logic      reset,

	pred_if.predictor lookup,

	// training from the back end
	input  logic      resolve_valid,
	input  addr_t     resolve_pc,
	input  logic      resolve_taken,
	input  addr_t     resolve_target
);

	////////////////////
	// storage
	////////////////////
	ctr_state_t bht [BHT_ENTRIES];          // direction counters
	logic       btb_valid [BTB_ENTRIES];    // entry holds a trained branch
	btb_tag_t   btb_tag [BTB_ENTRIES];
	addr_t      btb_target [BTB_ENTRIES];

	// lookup indices for both slots
	bht_idx_t bht_idx0;
	bht_idx_t bht_idx1;
	btb_idx_t btb_idx0;
	btb_idx_t btb_idx1;

	logic hit0;     // target buffer tag match
	logic hit1;

	// resolve side
	bht_idx_t   res_bht_idx;
	btb_idx_t   res_btb_idx;
	ctr_state_t res_ctr_next;

	////////////////////
	// lookup
	////////////////////
	assign bht_idx0 = bht_index(lookup.lookup_pc0);
	assign bht_idx1 = bht_index(lookup.lookup_pc1);
	assign btb_idx0 = btb_index(lookup.lookup_pc0);
	assign btb_idx1 = btb_index(lookup.lookup_pc1);

	// hit needs the full upper tag, no partial match
	assign hit0 = btb_valid[btb_idx0] && (btb_tag[btb_idx0] == btb_tag_of(lookup.lookup_pc0));
	assign hit1 = btb_valid[btb_idx1] && (btb_tag[btb_idx1] == btb_tag_of(lookup.lookup_pc1));

	assign lookup.pred_taken0  = hit0 && ctr_predicts_taken(bht[bht_idx0]);
	assign lookup.pred_taken1  = hit1 && ctr_predicts_taken(bht[bht_idx1]);
	assign lookup.pred_target0 = btb_target[btb_idx0];  // fetch masks it when not taken
	assign lookup.pred_target1 = btb_target[btb_idx1];

	////////////////////
	// training
	////////////////////
	assign res_bht_idx = bht_index(resolve_pc);
	assign res_btb_idx = btb_index(resolve_pc);

	// one step toward the resolved direction, saturating at both ends
	always_comb
	begin
		case (bht[res_bht_idx])
			strong_not_taken: res_ctr_next = resolve_taken ? weak_not_taken : strong_not_taken;
			weak_not_taken:   res_ctr_next = resolve_taken ? weak_taken     : strong_not_taken;
			weak_taken:       res_ctr_next = resolve_taken ? strong_taken   : weak_not_taken;
			strong_taken:     res_ctr_next = resolve_taken ? strong_taken   : weak_taken;
			default:          res_ctr_next = weak_not_taken;
		endcase
	end

	// counters and valid bits
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < BHT_ENTRIES; i++)
				bht[i] <= weak_not_taken;   // start just below taken
			for (int j = 0; j < BTB_ENTRIES; j++)
				btb_valid[j] <= 1'b0;
		end
		else if (resolve_valid)
		begin
			bht[res_bht_idx] <= res_ctr_next;
			if (resolve_taken)
				btb_valid[res_btb_idx] <= 1'b1;
		end
	end

	// tag and target, a taken resolve overwrites whatever branch sat there
	always_ff @(posedge clock)
	begin
		if (resolve_valid && resolve_taken)
		begin
			btb_tag[res_btb_idx]    <= btb_tag_of(resolve_pc);
			btb_target[res_btb_idx] <= resolve_target;
		end
	end

	////////////////////
	// checks
	////////////////////
	// back end only resolves instruction addresses
	a_resolve_aligned: assert property (@(posedge clock) disable iff (reset)
		resolve_valid |-> (resolve_pc[1:0] == 2'b00))
		else $error("resolve_pc %h is not word aligned", resolve_pc);

endmodule

//--- hw/fetch_pkg.sv
////////////////////
// types and table sizes for the two-wide fetch front end
// addresses are byte addresses and instructions are 32-bit words
// both predictor tables are direct mapped on pc bits above the word offset
// table sizes must stay powers of two
////////////////////
package fetch_pkg;

	////////////////////
	// datapath widths
	////////////////////
	typedef logic [63:0] addr_t;        // byte address
	typedef logic [31:0] instr_t;       // one instruction
	typedef logic [63:0] mem_word_t;    // one memory word holds two instructions

	typedef logic [1:0] dispatch_cnt_t; // slots taken by decode, 0 to 2

	localparam addr_t RESET_PC = 64'h0;

	////////////////////
	// predictor tables
	////////////////////
	localparam int BHT_ENTRIES = 64;
	localparam int BTB_ENTRIES = 32;

	typedef logic [$clog2(BHT_ENTRIES)-1:0] bht_idx_t;  // pc[7:2]
	typedef logic [$clog2(BTB_ENTRIES)-1:0] btb_idx_t;  // pc[6:2]
	typedef logic [56:0]                    btb_tag_t;  // pc[63:7]

	// two-bit saturating counter, upper half predicts taken
	typedef enum logic [1:0]
	{
		strong_not_taken = 2'b00,
		weak_not_taken   = 2'b01,
		weak_taken       = 2'b10,
		strong_taken     = 2'b11
	} ctr_state_t;

	// counter table index, word offset dropped
	function automatic bht_idx_t bht_index(input addr_t pc);
		return pc[7:2];
	endfunction

	// target buffer index
	function automatic btb_idx_t btb_index(input addr_t pc);
		return pc[6:2];
	endfunction

	// full tag, every bit above the index
	function automatic btb_tag_t btb_tag_of(input addr_t pc);
		return pc[63:7];
	endfunction

	// taken half of the counter range
	function automatic logic ctr_predicts_taken(input ctr_state_t state);
		return (state == weak_taken) || (state == strong_taken);
	endfunction

endpackage

//--- hw/fetch_stage.sv
////////////////////
// pc register and two-slot extraction from one 64-bit memory word
// memory answers imem_addr in the same cycle with data and valid
// decode must never accept more slots than are valid
// all outputs are combinational from pc, memory and predictor
////////////////////
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*;
(
	input  logic          clock,
	input  logic          reset,

	// instruction memory
	output addr_t         imem_addr,
	input  mem_word_t     imem_data,
	input  logic          imem_valid,

	input  dispatch_cnt_t dispatch_num,     // slots accepted this cycle

	pred_if.fetch         pred,

	// slot 0
	output logic          slot0_valid,
	output instr_t        slot0_instr,
	output addr_t         slot0_npc,
	output logic          slot0_pred_taken,
	output addr_t         slot0_pred_target,

	// slot 1
	output logic          slot1_valid,
	output instr_t        slot1_instr,
	output addr_t         slot1_npc,
	output logic          slot1_pred_taken,
	output addr_t         slot1_pred_target
);

	addr_t pc;              // address of slot 0
	addr_t pc_next;
	addr_t pc_plus_4;
	addr_t pc_plus_8;

	dispatch_cnt_t valid_count;     // slots offered to decode

	assign pc_plus_4 = pc + 64'd4;
	assign pc_plus_8 = pc + 64'd8;

	////////////////////
	// memory and lookup
	////////////////////
	assign imem_addr = {pc[63:3], 3'b000};  // aligned word holding pc

	assign pred.lookup_pc0 = pc;
	assign pred.lookup_pc1 = pc_plus_4;     // unused when pc[2] is set

	////////////////////
	// slots
	////////////////////
	// odd word position means only the upper half is left in this word
	assign slot0_instr = pc[2] ? imem_data[63:32] : imem_data[31:0];
	assign slot1_instr = imem_data[63:32];

	assign slot0_valid = imem_valid;
	// a taken slot 0 leaves the word, so slot 1 is dead
	assign slot1_valid = imem_valid && !pc[2] && !pred.pred_taken0;

	assign slot0_npc = pc_plus_4;
	assign slot1_npc = pc_plus_8;

	// predictions are zero in an empty slot
	assign slot0_pred_taken  = slot0_valid && pred.pred_taken0;
	assign slot1_pred_taken  = slot1_valid && pred.pred_taken1;
	assign slot0_pred_target = slot0_pred_taken ? pred.pred_target0 : '0;
	assign slot1_pred_target = slot1_pred_taken ? pred.pred_target1 : '0;

	assign valid_count = dispatch_cnt_t'(slot0_valid) + dispatch_cnt_t'(slot1_valid);

	////////////////////
	// next pc
	////////////////////
	// follow the last accepted slot, its target if predicted taken
	always_comb
	begin
		case (dispatch_num)
			2'd1:    pc_next = slot0_pred_taken ? slot0_pred_target : slot0_npc;
			2'd2:    pc_next = slot1_pred_taken ? slot1_pred_target : slot1_npc;
			default: pc_next = pc;     // nothing accepted, refetch same word
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= RESET_PC;
		else
			pc <= pc_next;
	end

	////////////////////
	// checks
	////////////////////
	// decode sees the valid flags, which depend on memory and predictor
	a_dispatch_le_valid: assert property (@(posedge clock) disable iff (reset)
		dispatch_num <= valid_count)
		else $error("dispatch_num %0d above valid slots %0d", dispatch_num, valid_count);

	a_dispatch_not_3: assert property (@(posedge clock) disable iff (reset)
		dispatch_num != 2'd3)
		else $error("dispatch_num of 3 on a two-wide front end");

endmodule

//--- hw/fetch_top.sv
////////////////////
// fetch front end top level
// instruction memory lives outside and answers in the same cycle
// resolve port trains the predictor only
////////////////////
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*;
(
	input  logic          clock,
	input  logic          reset,

	// instruction memory
	output addr_t         imem_addr,
	input  mem_word_t     imem_data,
	input  logic          imem_valid,

	// decode, slot 0
	output logic          slot0_valid,
	output instr_t        slot0_instr,
	output addr_t         slot0_npc,
	output logic          slot0_pred_taken,
	output addr_t         slot0_pred_target,

	// decode, slot 1
	output logic          slot1_valid,
	output instr_t        slot1_instr,
	output addr_t         slot1_npc,
	output logic          slot1_pred_taken,
	output addr_t         slot1_pred_target,

	input  dispatch_cnt_t dispatch_num,

	// resolve from the back end
	input  logic          resolve_valid,
	input  addr_t         resolve_pc,
	input  logic          resolve_taken,
	input  addr_t         resolve_target
);

	pred_if pred_bus ();    // fetch to predictor lookup

	branch_predictor u_predictor
	(
		.clock          (clock),
		.reset          (reset),
		.lookup         (pred_bus.predictor),
		.resolve_valid  (resolve_valid),
		.resolve_pc     (resolve_pc),
		.resolve_taken  (resolve_taken),
		.resolve_target (resolve_target)
	);

	fetch_stage u_fetch
	(
		.clock             (clock),
		.reset             (reset),
		.imem_addr         (imem_addr),
		.imem_data         (imem_data),
		.imem_valid        (imem_valid),
		.dispatch_num      (dispatch_num),
		.pred              (pred_bus.fetch),
		.slot0_valid       (slot0_valid),
		.slot0_instr       (slot0_instr),
		.slot0_npc         (slot0_npc),
		.slot0_pred_taken  (slot0_pred_taken),
		.slot0_pred_target (slot0_pred_target),
		.slot1_valid       (slot1_valid),
		.slot1_instr       (slot1_instr),
		.slot1_npc         (slot1_npc),
		.slot1_pred_taken  (slot1_pred_taken),
		.slot1_pred_target (slot1_pred_target)
	);

endmodule

//--- hw/pred_if.sv
////////////////////
// lookup path between fetch and the branch predictor
// two lookups per cycle, answered combinationally
////////////////////
`timescale 1ns/1ps

interface pred_if import fetch_pkg::*;
();

	// lookup addresses from fetch
	addr_t lookup_pc0;      // current pc
	addr_t lookup_pc1;      // pc + 4

	// answers from the predictor
	logic  pred_taken0;     // tag hit and counter in taken half
	logic  pred_taken1;
	addr_t pred_target0;    // stored target, meaningful only with pred_taken0
	addr_t pred_target1;

	modport fetch
	(
		output lookup_pc0,
		output lookup_pc1,
		input  pred_taken0,
		input  pred_taken1,
		input  pred_target0,
		input  pred_target1
	);

	modport predictor
	(
		input  lookup_pc0,
		input  lookup_pc1,
		output pred_taken0,
		output pred_taken1,
		output pred_target0,
		output pred_target1
	);

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module fetch_tb \
	-o fetch_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/fetch_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "pass message not found"
exit 1
